/* verilog/gpio_config.svh */
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// gpio block dimensions
////////////////////////////////////////////////////////////////////////////

// number of identical banks
`define GPIO_BANKS 3

// bits per bank, also the wishbone data width
`define GPIO_BANK_W 8

// wishbone address width
// bits 1:0 register, bits 3:2 bank, rest must be zero
`define GPIO_AW 8

`endif

/* verilog/gpio_pkg.sv */
`include "gpio_config.svh"

package gpio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register map inside one bank
  ////////////////////////////////////////////////////////////////////////////

  // offset in address bits 1:0
  typedef enum logic [1:0] {
    REG_OUT  = 2'd0,
    REG_DIR  = 2'd1,
    REG_IN   = 2'd2,
    REG_EDGE = 2'd3
  } gpio_reg_e;

  // one bank word, same width as the data bus
  typedef logic [`GPIO_BANK_W-1:0] bank_data_t;

endpackage

/* verilog/gpio_reg_if.sv */
`timescale 1ns/1ps

// register access path between decoder, one bank and the merger
interface gpio_reg_if
  import gpio_pkg::*;
();

  // request side, driven by the decoder
  logic       stb;
  logic       we;
  gpio_reg_e  reg_sel;
  bank_data_t dat_w;

  // response side, driven by the bank
  bank_data_t dat_r;
  logic       ack;
  logic       irq;

  modport master (output stb, we, reg_sel, dat_w);

  modport slave (input stb, we, reg_sel, dat_w, output dat_r, ack, irq);

  // merger only looks at the answers
  modport monitor (input ack, dat_r, irq);

endinterface

/* verilog/wb_bank_decoder.sv */
`timescale 1ns/1ps
`include "gpio_config.svh"

module wb_bank_decoder
  import gpio_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [`GPIO_AW-1:0] adr,
  input  bank_data_t          dat_w,
  output logic                err,
  gpio_reg_if.master          bank [`GPIO_BANKS]
);

  // bank field position in the address
  localparam int BANK_LSB  = 2;
  localparam int BANK_BITS = 2;

  logic                 valid;
  logic [BANK_BITS-1:0] bank_idx;
  logic                 upper_zero;
  logic                 mapped;

  ////////////////////////////////////////////////////////////////////////////
  // address check
  ////////////////////////////////////////////////////////////////////////////

  assign valid      = cyc & stb;
  assign bank_idx   = adr[BANK_LSB +: BANK_BITS];
  // upper nibble must be clear
  assign upper_zero = (adr[`GPIO_AW-1:BANK_LSB+BANK_BITS] == '0);
  // bank index 3 has no bank behind it
  assign mapped     = upper_zero && (int'(bank_idx) < `GPIO_BANKS);

  // one-cycle error answer, held off by its own previous pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      err <= 1'b0;
    end else begin
      err <= valid & ~mapped & ~err;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-bank request fan-out
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < `GPIO_BANKS; i++) begin : g_strobe
      // strobe only the addressed bank
      assign bank[i].stb     = valid & mapped & (bank_idx == BANK_BITS'(i));
      // shared request fields
      assign bank[i].we      = we;
      assign bank[i].reg_sel = gpio_reg_e'(adr[1:0]);
      assign bank[i].dat_w   = dat_w;
    end
  endgenerate

endmodule

/* verilog/gpio_bank.sv */
`timescale 1ns/1ps
`include "gpio_config.svh"

module gpio_bank
  import gpio_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  gpio_reg_if.slave  bus,
  input  bank_data_t pin_i,
  output bank_data_t pin_o,
  output bank_data_t pin_t
);

  // control registers
  bank_data_t out_q;
  bank_data_t dir_q;

  // input path
  bank_data_t sync_a;
  bank_data_t sync_b;
  bank_data_t prev_q;

  // edge status
  bank_data_t edge_q;
  bank_data_t rise;
  bank_data_t clr;

  logic ack_q;
  logic wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // act on the first strobe cycle only, stb is still high in the ack cycle
  assign wr_en = bus.stb & bus.we & ~ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.stb & ~ack_q;
    end
  end

  assign bus.ack = ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // output and direction registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_q <= '0;
      // all lines start as inputs
      dir_q <= '1;
    end else if (wr_en) begin
      case (bus.reg_sel)
        REG_OUT: out_q <= bus.dat_w;
        REG_DIR: dir_q <= bus.dat_w;
        // REG_IN is read only, REG_EDGE handled below
        default: ;
      endcase
    end
  end

  assign pin_o = out_q;
  assign pin_t = dir_q;

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer and edge detect
  ////////////////////////////////////////////////////////////////////////////

  // keeps tracking the pins through reset so no false edge follows it
  always_ff @(posedge clk) begin
    sync_a <= pin_i;
    sync_b <= sync_a;
    prev_q <= sync_b;
  end

  assign rise = sync_b & ~prev_q;

  // write-one-to-clear mask
  assign clr = (wr_en && bus.reg_sel == REG_EDGE) ? bus.dat_w : '0;

  // a new rising edge beats a clear on the same bit
  always_ff @(posedge clk) begin
    if (rst) begin
      edge_q <= '0;
    end else begin
      edge_q <= (edge_q & ~clr) | rise;
    end
  end

  assign bus.irq = |edge_q;

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  // address is stable during the ack cycle, so a plain mux is enough
  always_comb begin
    case (bus.reg_sel)
      REG_OUT:  bus.dat_r = out_q;
      REG_DIR:  bus.dat_r = dir_q;
      REG_IN:   bus.dat_r = sync_b;
      REG_EDGE: bus.dat_r = edge_q;
      default:  bus.dat_r = '0;
    endcase
  end

endmodule

/* verilog/wb_response_merge.sv */
`timescale 1ns/1ps
`include "gpio_config.svh"

module wb_response_merge
  import gpio_pkg::*;
(
  gpio_reg_if.monitor bank [`GPIO_BANKS],
  output logic        ack,
  output bank_data_t  dat_r,
  output logic        irq
);

  logic [`GPIO_BANKS-1:0] ack_vec;
  logic [`GPIO_BANKS-1:0] irq_vec;
  // read data already masked by each bank's ack
  bank_data_t             dat_vec [`GPIO_BANKS];

  ////////////////////////////////////////////////////////////////////////////
  // collect per-bank answers
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < `GPIO_BANKS; i++) begin : g_collect
      assign ack_vec[i] = bank[i].ack;
      assign irq_vec[i] = bank[i].irq;
      assign dat_vec[i] = bank[i].ack ? bank[i].dat_r : '0;
    end
  endgenerate

  ////////////////////////////////////////////////////////////////////////////
  // bus-side responses
  ////////////////////////////////////////////////////////////////////////////

  // at most one bank answers, classic cycle
  assign ack = |ack_vec;

  // OR of masked words, zero when nobody acks
  always_comb begin
    dat_r = '0;
    for (int i = 0; i < `GPIO_BANKS; i++) begin
      dat_r = dat_r | dat_vec[i];
    end
  end

  // single interrupt line for all banks
  assign irq = |irq_vec;

endmodule

/* verilog/gpio_system.sv */
`timescale 1ns/1ps
`include "gpio_config.svh"

module gpio_system
  import gpio_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  // wishbone classic slave
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [`GPIO_AW-1:0]               wb_adr,
  input  bank_data_t                        wb_dat_w,
  output bank_data_t                        wb_dat_r,
  output logic                              wb_ack,
  output logic                              wb_err,
  // tri-state gpio lines
  input  logic [`GPIO_BANKS*`GPIO_BANK_W-1:0] gpio_i,
  output logic [`GPIO_BANKS*`GPIO_BANK_W-1:0] gpio_o,
  output logic [`GPIO_BANKS*`GPIO_BANK_W-1:0] gpio_t,
  // edge interrupt
  output logic                              irq
);

  // one register path per bank
  gpio_reg_if bank_if [`GPIO_BANKS] ();

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  wb_bank_decoder u_decoder (
    .clk   (clk),
    .rst   (rst),
    .cyc   (wb_cyc),
    .stb   (wb_stb),
    .we    (wb_we),
    .adr   (wb_adr),
    .dat_w (wb_dat_w),
    .err   (wb_err),
    .bank  (bank_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // gpio banks
  ////////////////////////////////////////////////////////////////////////////

  // bank i owns lines i*8 up to i*8+7
  generate
    for (genvar i = 0; i < `GPIO_BANKS; i++) begin : g_bank
      gpio_bank u_bank (
        .clk   (clk),
        .rst   (rst),
        .bus   (bank_if[i]),
        .pin_i (gpio_i[i*`GPIO_BANK_W +: `GPIO_BANK_W]),
        .pin_o (gpio_o[i*`GPIO_BANK_W +: `GPIO_BANK_W]),
        .pin_t (gpio_t[i*`GPIO_BANK_W +: `GPIO_BANK_W])
      );
    end
  endgenerate

  ////////////////////////////////////////////////////////////////////////////
  // response merge
  ////////////////////////////////////////////////////////////////////////////

  wb_response_merge u_merge (
    .bank  (bank_if),
    .ack   (wb_ack),
    .dat_r (wb_dat_r),
    .irq   (irq)
  );

endmodule

/* bench/gpio_system_tb.sv */
`timescale 1ns/1ps
`include "gpio_config.svh"

module gpio_system_tb
  import gpio_pkg::*;
();

  // table operations
  // poll retries until the value settles
  typedef enum logic [1:0] {OP_WR, OP_RD, OP_POLL} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  adr;
    logic [7:0]  wdat;
    logic [23:0] gin;
    logic [7:0]  exp;
    logic        exp_err;
  } row_t;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic [23:0] gpio_i;
  logic [23:0] gpio_o;
  logic [23:0] gpio_t;
  logic        irq;

  row_t        tbl [$];
  logic [23:0] cur_gin;
  integer      seed = 72;
  int          cycle_cnt = 0;

  // expected register state per bank
  // index 3 never used
  logic [7:0]  out_m  [4];
  logic [7:0]  dir_m  [4];
  logic [7:0]  edge_m [4];
  logic [23:0] gin_m;

  gpio_system UUT (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_t   (gpio_t),
    .irq      (irq)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  // pins and irq against the model at mid-cycle
  task automatic check_outputs();
    @(negedge clk);
    check_value("gpio_o", gpio_o, {out_m[2], out_m[1], out_m[0]});
    check_value("gpio_t", gpio_t, {dir_m[2], dir_m[1], dir_m[0]});
    check_value("irq", {23'h0, irq}, {23'h0, |{edge_m[2], edge_m[1], edge_m[0]}});
    // bus idle one cycle after the answer
    check_value("wb_ack", {23'h0, wb_ack}, 24'h0);
    check_value("wb_err", {23'h0, wb_err}, 24'h0);
    check_value("wb_dat_r", {16'h0, wb_dat_r}, 24'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [7:0] wdat,
                           output logic ack, output logic err, output logic [7:0] rdat);
    int waited;
    waited = 0;
    ack = 1'b0;
    err = 1'b0;
    rdat = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    // wait at most 20 cycles for either answer
    while (!(ack || err) && waited < 20) begin
      @(negedge clk);
      ack  = wb_ack;
      err  = wb_err;
      rdat = wb_dat_r;
      waited++;
    end
    if (!(ack || err)) begin
      $display("bus cycle to address %h got neither ack nor err in 20 cycles", adr);
      $display("=== FAIL ===");
      $fatal(1, "bus timeout");
    end
    // drop the strobe in the cycle after the answer
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [7:0] wdat,
                           output logic ack, output logic err);
    logic [7:0] unused_rdat;
    bus_cycle(1'b1, adr, wdat, ack, err, unused_rdat);
  endtask

  task automatic bus_read(input logic [7:0] adr, output logic ack, output logic err,
                          output logic [7:0] rdat);
    bus_cycle(1'b0, adr, 8'h00, ack, err, rdat);
  endtask

  // re-read until the synchronized value shows up
  task automatic poll_read(input logic [7:0] adr, input logic [7:0] exp,
                           output logic ack, output logic err, output logic [7:0] rdat);
    int start;
    start = cycle_cnt;
    bus_read(adr, ack, err, rdat);
    while (ack && rdat !== exp && cycle_cnt - start < 10) begin
      bus_read(adr, ack, err, rdat);
    end
    if (ack && rdat !== exp) begin
      $display("address %h did not settle to %h within 10 cycles", adr, exp);
      $display("=== FAIL ===");
      $fatal(1, "poll timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] adr_of(input int bank, input gpio_reg_e r);
    return {4'h0, bank[1:0], r};
  endfunction

  task automatic add_row(input op_e op, input logic [7:0] adr, input logic [7:0] wdat,
                         input logic [7:0] exp, input logic exp_err);
    row_t row;
    row = '{op: op, adr: adr, wdat: wdat, gin: cur_gin, exp: exp, exp_err: exp_err};
    tbl.push_back(row);
  endtask

  task automatic build_table();
    int         rnd;
    logic [7:0] out_r [3];
    logic [7:0] dir_r [3];
    cur_gin = '0;
    // reset values
    for (int b = 0; b < `GPIO_BANKS; b++) begin
      add_row(OP_RD, adr_of(b, REG_OUT), 8'h00, 8'h00, 1'b0);
      add_row(OP_RD, adr_of(b, REG_DIR), 8'h00, 8'hff, 1'b0);
    end
    // random output and direction words
    for (int b = 0; b < `GPIO_BANKS; b++) begin
      rnd = $random(seed);
      out_r[b] = rnd[7:0];
      rnd = $random(seed);
      dir_r[b] = rnd[7:0];
      add_row(OP_WR, adr_of(b, REG_OUT), out_r[b], 8'h00, 1'b0);
      add_row(OP_WR, adr_of(b, REG_DIR), dir_r[b], 8'h00, 1'b0);
      add_row(OP_RD, adr_of(b, REG_OUT), 8'h00, out_r[b], 1'b0);
      add_row(OP_RD, adr_of(b, REG_DIR), 8'h00, dir_r[b], 1'b0);
    end
    // random inputs through the synchronizer
    rnd = $random(seed);
    cur_gin = rnd[23:0];
    for (int b = 0; b < `GPIO_BANKS; b++) begin
      add_row(OP_POLL, adr_of(b, REG_IN), 8'h00, cur_gin[b*8 +: 8], 1'b0);
    end
    // back to zero and clear leftover edges
    cur_gin = '0;
    add_row(OP_POLL, adr_of(0, REG_IN), 8'h00, 8'h00, 1'b0);
    for (int b = 0; b < `GPIO_BANKS; b++) begin
      add_row(OP_WR, adr_of(b, REG_EDGE), 8'hff, 8'h00, 1'b0);
    end
    // chosen rising bits in every bank
    cur_gin = 24'h81_40_14;
    add_row(OP_POLL, adr_of(0, REG_EDGE), 8'h00, 8'h14, 1'b0);
    add_row(OP_RD, adr_of(1, REG_EDGE), 8'h00, 8'h40, 1'b0);
    add_row(OP_RD, adr_of(2, REG_EDGE), 8'h00, 8'h81, 1'b0);
    add_row(OP_WR, adr_of(0, REG_EDGE), 8'h04, 8'h00, 1'b0);
    add_row(OP_RD, adr_of(0, REG_EDGE), 8'h00, 8'h10, 1'b0);
    add_row(OP_WR, adr_of(0, REG_EDGE), 8'h10, 8'h00, 1'b0);
    add_row(OP_WR, adr_of(1, REG_EDGE), 8'h40, 8'h00, 1'b0);
    add_row(OP_WR, adr_of(2, REG_EDGE), 8'hff, 8'h00, 1'b0);
    // inputs stay high so no new edge
    add_row(OP_RD, adr_of(2, REG_EDGE), 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, adr_of(0, REG_EDGE), 8'h00, 8'h00, 1'b0);
    // unmapped bank 3 and nonzero upper nibble
    add_row(OP_WR, 8'h0c, 8'h5a, 8'h00, 1'b1);
    add_row(OP_WR, 8'h40, 8'ha5, 8'h00, 1'b1);
    add_row(OP_WR, 8'h41, 8'h3c, 8'h00, 1'b1);
    add_row(OP_RD, 8'h1d, 8'h00, 8'h00, 1'b1);
    add_row(OP_RD, adr_of(0, REG_OUT), 8'h00, out_r[0], 1'b0);
    add_row(OP_RD, adr_of(0, REG_DIR), 8'h00, dir_r[0], 1'b0);
    // REG_IN is read only
    add_row(OP_WR, adr_of(1, REG_IN), 8'hbf, 8'h00, 1'b0);
    add_row(OP_RD, adr_of(1, REG_IN), 8'h00, 8'h40, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t       row;
    logic       ack;
    logic       err;
    logic [7:0] rdat;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    gpio_i   = '0;
    gin_m    = '0;
    for (int b = 0; b < 4; b++) begin
      out_m[b]  = 8'h00;
      dir_m[b]  = 8'hff;
      edge_m[b] = 8'h00;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    build_table();
    check_outputs();

    foreach (tbl[i]) begin
      row = tbl[i];
      // new input word
      // its rising bits go into the edge model
      if (row.gin !== gin_m) begin
        @(posedge clk);
        gpio_i <= row.gin;
        for (int b = 0; b < `GPIO_BANKS; b++) begin
          edge_m[b] = edge_m[b] | (row.gin[b*8 +: 8] & ~gin_m[b*8 +: 8]);
        end
        gin_m = row.gin;
      end
      case (row.op)
        OP_WR:   bus_write(row.adr, row.wdat, ack, err);
        OP_RD:   bus_read(row.adr, ack, err, rdat);
        default: poll_read(row.adr, row.exp, ack, err, rdat);
      endcase
      check_value("wb_err", {23'h0, err}, {23'h0, row.exp_err});
      check_value("wb_ack", {23'h0, ack}, {23'h0, ~row.exp_err});
      if (row.op != OP_WR && !row.exp_err) begin
        check_value("wb_dat_r", {16'h0, rdat}, {16'h0, row.exp});
      end
      // accepted writes update the model
      if (row.op == OP_WR && !row.exp_err) begin
        case (gpio_reg_e'(row.adr[1:0]))
          REG_OUT:  out_m[row.adr[3:2]] = row.wdat;
          REG_DIR:  dir_m[row.adr[3:2]] = row.wdat;
          REG_EDGE: edge_m[row.adr[3:2]] = edge_m[row.adr[3:2]] & ~row.wdat;
          default:  ;
        endcase
      end
      check_outputs();
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* gpio_system.f */
+incdir+verilog
verilog/gpio_pkg.sv
verilog/gpio_reg_if.sv
verilog/wb_bank_decoder.sv
verilog/gpio_bank.sv
verilog/wb_response_merge.sv
verilog/gpio_system.sv
bench/gpio_system_tb.sv

/* Makefile */
TOP = gpio_system_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f gpio_system.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
